/* sources.f */
common/icache_pkg.sv
rtl/way_store.sv
rtl/hit_select.sv
refill/refill_ctrl.sv
rtl/icache_top.sv
verif/mem_model.sv
verif/icache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
FAIL_TEXT="Simulation failed"

verilator --binary --timing --assert --top-module icache_tb \
    -f sources.f -o icache_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator compile step returned an error"
    exit 1
fi

./obj_dir/icache_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "$FAIL_TEXT" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
exit 0

/* verif/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int SET_NUM   = 128;
    localparam int CLK_NS    = 10;
    localparam int N_ENTRIES = 17;
    localparam int RSP_LIMIT = 100;

    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  mask;
        logic        flush;
        logic        miss;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    fetch_pkt_t  fetch_pkt;
    logic        fetch_ready;
    logic        rsp_valid;
    fetch_rsp_t  rsp;
    logic        flush;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_ack;
    logic        mem_data_valid;
    logic [31:0] mem_data;

    entry_t stim [N_ENTRIES];

    icache_top #(
        .SET_NUM(SET_NUM)
    ) icache_top_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_valid_i    (fetch_valid),
        .fetch_i          (fetch_pkt),
        .fetch_ready_o    (fetch_ready),
        .rsp_valid_o      (rsp_valid),
        .rsp_o            (rsp),
        .flush_i          (flush),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_o        (mem_req),
        .mem_ack_i        (mem_ack),
        .mem_data_valid_i (mem_data_valid),
        .mem_data_i       (mem_data)
    );

    mem_model #(
        .SEED(16'd77)
    ) mem_model_inst (
        .clk              (clk),
        .mem_req_valid_i  (mem_req_valid),
        .mem_req_i        (mem_req),
        .mem_ack_o        (mem_ack),
        .mem_data_valid_o (mem_data_valid),
        .mem_data_o       (mem_data)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {~addr[31:16], addr[15:0]};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else
            fail_run($sformatf("Fail %s got %08h expected %08h", name, got, exp));
    endtask

    // response fields, then the single-cycle valid
    task automatic check_rsp(input entry_t e);
        check_word("rsp_o.pc", rsp.pc, e.pc);
        check_word("rsp_o.mask", 32'(rsp.mask), 32'(e.mask));
        check_word("rsp_o.insts[0]", rsp.insts[0], expected_word(e.pc));
        check_word("rsp_o.insts[1]", rsp.insts[1], expected_word(e.pc + 32'd4));
        @(negedge clk);
        assert (rsp_valid === 1'b0) else fail_run("rsp_valid_o high for more than one cycle");
    endtask

    task automatic apply_entry(input entry_t e);
        int waited;
        waited = 0;
        assert (fetch_ready === 1'b1) else fail_run("fetch_ready_o low before a new packet");
        fetch_valid    = 1'b1;
        fetch_pkt.pc   = e.pc;
        fetch_pkt.mask = e.mask;
        @(negedge clk);
        fetch_valid = 1'b0;
        if (e.mask == 2'b00) begin
            repeat (2) begin
                assert (rsp_valid === 1'b0 && mem_req_valid === 1'b0) else
                    fail_run("bubble packet gave a response or a memory request");
                @(negedge clk);
            end
        end else if (e.miss) begin
            assert (mem_req_valid === 1'b1) else fail_run("miss raised no memory request");
            check_word("mem_req_o.addr", mem_req.addr, {e.pc[31:5], 5'b0});
            check_word("mem_req_o.len", 32'(mem_req.len), 32'd8);
            if (e.flush) begin
                // flush once the refill is under way
                @(negedge clk);
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                while (fetch_ready !== 1'b1 && waited < RSP_LIMIT) begin
                    assert (rsp_valid === 1'b0) else fail_run("flushed refill gave a response");
                    @(negedge clk);
                    waited++;
                end
                assert (fetch_ready === 1'b1 && rsp_valid === 1'b0) else
                    fail_run("refill after a flush did not end cleanly");
            end else begin
                while (rsp_valid !== 1'b1 && waited < RSP_LIMIT) begin
                    assert (fetch_ready === 1'b0) else fail_run("fetch_ready_o high during a refill");
                    @(negedge clk);
                    waited++;
                end
                assert (rsp_valid === 1'b1) else fail_run("refill gave no response in time");
                assert (fetch_ready === 1'b1) else
                    fail_run("fetch_ready_o still low in the response cycle");
                check_rsp(e);
            end
        end else begin
            assert (rsp_valid === 1'b0 && mem_req_valid === 1'b0) else
                fail_run("early response or memory request on a hit");
            @(negedge clk);
            assert (rsp_valid === 1'b1) else fail_run("no response in the second cycle of a hit");
            assert (mem_req_valid === 1'b0) else fail_run("memory request on a hit");
            check_rsp(e);
        end
    endtask

    initial begin
        #(N_ENTRIES * 100 * CLK_NS);
        fail_run("watchdog expired before the table was done");
    end

    initial begin
        // pc, mask, flush, expect miss
        stim[0]  = {32'h0000_1040, 2'b11, 1'b0, 1'b1};
        stim[1]  = {32'h0000_1040, 2'b11, 1'b0, 1'b0};
        stim[2]  = {32'h0000_1048, 2'b11, 1'b0, 1'b0};
        // same set, second tag
        stim[3]  = {32'h0000_2040, 2'b11, 1'b0, 1'b1};
        stim[4]  = {32'h0000_1040, 2'b11, 1'b0, 1'b0};
        stim[5]  = {32'h0000_2058, 2'b11, 1'b0, 1'b0};
        // third tag evicts 0x1040, victim bit then points at 0x2040
        stim[6]  = {32'h0000_3040, 2'b11, 1'b0, 1'b1};
        stim[7]  = {32'h0000_2040, 2'b11, 1'b0, 1'b0};
        stim[8]  = {32'h0000_1058, 2'b11, 1'b0, 1'b1};
        stim[9]  = {32'h0000_3040, 2'b11, 1'b0, 1'b0};
        stim[10] = {32'h0000_0100, 2'b00, 1'b0, 1'b0};
        stim[11] = {32'h0000_0100, 2'b01, 1'b0, 1'b1};
        stim[12] = {32'h0000_0108, 2'b10, 1'b0, 1'b0};
        stim[13] = {32'h0000_4080, 2'b11, 1'b1, 1'b1};
        stim[14] = {32'h0000_4098, 2'b11, 1'b0, 1'b0};
        stim[15] = {32'h0000_4080, 2'b01, 1'b0, 1'b0};
        stim[16] = {32'h0000_1040, 2'b11, 1'b0, 1'b0};

        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pkt   = '0;
        flush       = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        assert (rsp_valid === 1'b0 && mem_req_valid === 1'b0 && fetch_ready === 1'b1) else
            fail_run("outputs not idle after reset");

        for (int i = 0; i < N_ENTRIES; i++) begin
            apply_entry(stim[i]);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* verif/mem_model.sv */
`timescale 1ns/1ps

module mem_model #(
    parameter logic [15:0] SEED = 16'd77
) (
    input  logic                 clk,
    input  logic                 mem_req_valid_i,
    input  icache_pkg::mem_req_t mem_req_i,
    output logic                 mem_ack_o,
    output logic                 mem_data_valid_o,
    output logic [31:0]          mem_data_o
);
    import icache_pkg::*;

    logic [15:0] lfsr_q;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = (val << 1) | int'(lfsr_q[0]);
        end
    endtask

    // word at byte address A is A with its upper half inverted
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {~addr[31:16], addr[15:0]};
    endfunction

    initial begin
        int          ack_wait;
        int          gap;
        logic [31:0] base;
        lfsr_q           = SEED;
        mem_ack_o        = 1'b0;
        mem_data_valid_o = 1'b0;
        mem_data_o       = '0;
        forever begin
            @(negedge clk);
            if (mem_req_valid_i === 1'b1) begin
                base = mem_req_i.addr;
                take_bits(2, ack_wait);
                repeat (ack_wait) @(negedge clk);
                mem_ack_o = 1'b1;
                @(negedge clk);
                mem_ack_o = 1'b0;
                // words in address order, random gaps between them
                for (int w = 0; w < LINE_WORDS; w++) begin
                    take_bits(2, gap);
                    repeat (gap) @(negedge clk);
                    mem_data_valid_o = 1'b1;
                    mem_data_o       = word_at(base + 32'(w * 4));
                    @(negedge clk);
                    mem_data_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
    parameter int SET_NUM = 128
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // fetch side
    input  logic                   fetch_valid_i,
    input  icache_pkg::fetch_pkt_t fetch_i,
    output logic                   fetch_ready_o,
    output logic                   rsp_valid_o,
    output icache_pkg::fetch_rsp_t rsp_o,
    input  logic                   flush_i,
    // memory side
    output logic                   mem_req_valid_o,
    output icache_pkg::mem_req_t   mem_req_o,
    input  logic                   mem_ack_i,
    input  logic                   mem_data_valid_i,
    input  logic [31:0]            mem_data_i
);
    import icache_pkg::*;

    logic                                         rd_en;
    logic [31:0]                                  rd_pc;
    line_write_t                                  wr;
    tag_entry_t [WAY_NUM-1:0]                     tags;
    logic [WAY_NUM-1:0][FETCH_WORDS-1:0][31:0]    pairs;
    logic                                         miss;
    fetch_pkt_t                                   miss_pkt;
    logic                                         busy;
    logic                                         miss_rsp_valid;
    fetch_rsp_t                                   miss_rsp;

    way_store #(
        .SET_NUM(SET_NUM)
    ) way_store_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_en_i (rd_en),
        .rd_pc_i (rd_pc),
        .wr_i    (wr),
        .tags_o  (tags),
        .pairs_o (pairs)
    );

    hit_select #(
        .SET_NUM(SET_NUM)
    ) hit_select_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_i          (fetch_i),
        .flush_i          (flush_i),
        .busy_i           (busy),
        .tags_i           (tags),
        .pairs_i          (pairs),
        .miss_rsp_valid_i (miss_rsp_valid),
        .miss_rsp_i       (miss_rsp),
        .fetch_ready_o    (fetch_ready_o),
        .rd_en_o          (rd_en),
        .rd_pc_o          (rd_pc),
        .miss_o           (miss),
        .miss_pkt_o       (miss_pkt),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_o            (rsp_o)
    );

    refill_ctrl #(
        .SET_NUM(SET_NUM)
    ) refill_ctrl_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .miss_i           (miss),
        .miss_pkt_i       (miss_pkt),
        .mem_ack_i        (mem_ack_i),
        .mem_data_valid_i (mem_data_valid_i),
        .mem_data_i       (mem_data_i),
        .flush_i          (flush_i),
        .busy_o           (busy),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .wr_o             (wr),
        .miss_rsp_valid_o (miss_rsp_valid),
        .miss_rsp_o       (miss_rsp)
    );

endmodule

/* refill/refill_ctrl.sv */
`timescale 1ns/1ps

module refill_ctrl #(
    parameter int SET_NUM = 128
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    miss_i,
    input  icache_pkg::fetch_pkt_t  miss_pkt_i,
    input  logic                    mem_ack_i,
    input  logic                    mem_data_valid_i,
    input  logic [31:0]             mem_data_i,
    input  logic                    flush_i,
    output logic                    busy_o,
    output logic                    mem_req_valid_o,
    output icache_pkg::mem_req_t    mem_req_o,
    output icache_pkg::line_write_t wr_o,
    output logic                    miss_rsp_valid_o,
    output icache_pkg::fetch_rsp_t  miss_rsp_o
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(SET_NUM);
    localparam int CNT_W = $clog2(LINE_WORDS);
    localparam int POS_W = $clog2(LINE_WORDS / FETCH_WORDS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_GATHER
    } state_t;

    state_t                       state_q;
    state_t                       state_d;
    fetch_pkt_t                   pkt_q;
    logic [CNT_W-1:0]             cnt_q;
    logic [31:0]                  lo_q;
    logic [FETCH_WORDS-1:0][31:0] pair_q;
    logic [FETCH_WORDS-1:0][31:0] cur_pair;
    logic                         flushed_q;
    logic [SET_NUM-1:0]           victim_q;
    logic [IDX_W-1:0]             miss_idx;
    logic [POS_W-1:0]             req_pos;
    logic [POS_W-1:0]             cur_pos;
    logic [31:0]                  req_pc;
    logic                         pair_done;
    logic                         line_done;

    assign miss_idx  = pkt_q.pc[OFFSET_BITS +: IDX_W];
    assign req_pos   = pkt_q.pc[OFFSET_BITS-1 -: POS_W];
    assign cur_pos   = cnt_q[CNT_W-1 -: POS_W];
    assign cur_pair  = {mem_data_i, lo_q};
    // odd word closes a pair
    assign pair_done = (state_q == ST_GATHER) && mem_data_valid_i && cnt_q[0];
    assign line_done = pair_done && (&cnt_q);

    // request goes out in the miss cycle itself
    assign req_pc          = (state_q == ST_IDLE) ? miss_pkt_i.pc : pkt_q.pc;
    assign mem_req_valid_o = ((state_q == ST_IDLE) && miss_i) || (state_q == ST_REQ);
    assign mem_req_o.addr  = {req_pc[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign mem_req_o.len   = 8'(LINE_WORDS);
    assign busy_o          = (state_q != ST_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss_i) begin
                    state_d = mem_ack_i ? ST_GATHER : ST_REQ;
                end
            end
            ST_REQ: begin
                if (mem_ack_i) begin
                    state_d = ST_GATHER;
                end
            end
            ST_GATHER: begin
                if (line_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            cnt_q     <= '0;
            flushed_q <= 1'b0;
            victim_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                cnt_q     <= '0;
                flushed_q <= 1'b0;
            end else begin
                if ((state_q == ST_GATHER) && mem_data_valid_i) begin
                    cnt_q <= cnt_q + 1'b1;
                end
                // line is still written, only the response is dropped
                if (flush_i) begin
                    flushed_q <= 1'b1;
                end
            end
            // next miss in this set takes the other way
            if (line_done) begin
                victim_q[miss_idx] <= ~victim_q[miss_idx];
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && miss_i) begin
            pkt_q <= miss_pkt_i;
        end
        if ((state_q == ST_GATHER) && mem_data_valid_i && !cnt_q[0]) begin
            lo_q <= mem_data_i;
        end
        // requested pair kept for the response
        if (pair_done && (cur_pos == req_pos)) begin
            pair_q <= cur_pair;
        end
    end

    always_comb begin
        wr_o                  = '0;
        wr_o.we               = pair_done;
        wr_o.way              = victim_q[miss_idx];
        wr_o.index[IDX_W-1:0] = miss_idx;
        wr_o.pos              = cur_pos;
        wr_o.tag              = pkt_q.pc[OFFSET_BITS+IDX_W +: TAG_BITS];
        wr_o.pair             = cur_pair;
    end

    assign miss_rsp_valid_o = line_done && !flushed_q && !flush_i;

    always_comb begin
        miss_rsp_o.pc    = pkt_q.pc;
        miss_rsp_o.mask  = pkt_q.mask;
        // last pair may be the requested one and is not in the buffer yet
        miss_rsp_o.insts = (cur_pos == req_pos) ? cur_pair : pair_q;
    end

endmodule

/* rtl/hit_select.sv */
`timescale 1ns/1ps

module hit_select #(
    parameter int SET_NUM = 128
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fetch_valid_i,
    input  icache_pkg::fetch_pkt_t fetch_i,
    input  logic                   flush_i,
    input  logic                   busy_i,
    input  icache_pkg::tag_entry_t [icache_pkg::WAY_NUM-1:0] tags_i,
    input  logic [icache_pkg::WAY_NUM-1:0][icache_pkg::FETCH_WORDS-1:0][31:0] pairs_i,
    input  logic                   miss_rsp_valid_i,
    input  icache_pkg::fetch_rsp_t miss_rsp_i,
    output logic                   fetch_ready_o,
    output logic                   rd_en_o,
    output logic [31:0]            rd_pc_o,
    output logic                   miss_o,
    output icache_pkg::fetch_pkt_t miss_pkt_o,
    output logic                   rsp_valid_o,
    output icache_pkg::fetch_rsp_t rsp_o
);
    import icache_pkg::*;

    localparam int IDX_W = $clog2(SET_NUM);

    fetch_pkt_t          pkt_q;
    fetch_rsp_t          rsp_q;
    logic                rsp_valid_q;
    logic [TAG_BITS-1:0] pkt_tag;
    logic [WAY_NUM-1:0]  way_hit;
    logic                hit_way;
    logic                pkt_live;
    logic                hit_valid;

    assign pkt_tag  = pkt_q.pc[OFFSET_BITS+IDX_W +: TAG_BITS];
    assign pkt_live = |pkt_q.mask;

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            way_hit[w] = tags_i[w].valid && (tags_i[w].tag == pkt_tag);
        end
    end

    assign hit_way   = way_hit[1];
    assign hit_valid = pkt_live && (|way_hit) && !busy_i;
    // a flushed packet never starts a refill
    assign miss_o    = pkt_live && !(|way_hit) && !busy_i && !flush_i;

    assign fetch_ready_o = !busy_i && !miss_o;
    // zero mask is a bubble and skips the lookup
    assign rd_en_o       = fetch_valid_i && fetch_ready_o && (|fetch_i.mask);
    assign rd_pc_o       = fetch_i.pc;
    assign miss_pkt_o    = pkt_q;

    // packet in the lookup stage, refill keeps its own copy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_q <= '0;
        end else if (flush_i || busy_i) begin
            pkt_q <= '0;
        end else if (fetch_ready_o) begin
            pkt_q <= fetch_valid_i ? fetch_i : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= (hit_valid || miss_rsp_valid_i) && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_valid) begin
            rsp_q.pc    <= pkt_q.pc;
            rsp_q.mask  <= pkt_q.mask;
            rsp_q.insts <= pairs_i[hit_way];
        end else if (miss_rsp_valid_i) begin
            rsp_q <= miss_rsp_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

/* rtl/way_store.sv */
`timescale 1ns/1ps

module way_store #(
    parameter int SET_NUM = 128
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  rd_en_i,
    input  logic [31:0]                           rd_pc_i,
    input  icache_pkg::line_write_t               wr_i,
    output icache_pkg::tag_entry_t [icache_pkg::WAY_NUM-1:0] tags_o,
    output logic [icache_pkg::WAY_NUM-1:0][icache_pkg::FETCH_WORDS-1:0][31:0] pairs_o
);
    import icache_pkg::*;

    localparam int IDX_W   = $clog2(SET_NUM);
    localparam int PAIRS   = LINE_WORDS / FETCH_WORDS;
    localparam int POS_W   = $clog2(PAIRS);

    logic [IDX_W-1:0]             rd_idx;
    logic [POS_W-1:0]             rd_pos;
    logic [IDX_W-1:0]             wr_idx;
    logic                         wr_last;
    logic [WAY_NUM-1:0][SET_NUM-1:0] valid_q;

    logic [TAG_BITS-1:0]          tag_mem  [WAY_NUM][SET_NUM];
    logic [FETCH_WORDS-1:0][31:0] data_mem [WAY_NUM][SET_NUM*PAIRS];

    // index above the line offset, pair position at bits 4:3
    assign rd_idx  = rd_pc_i[OFFSET_BITS +: IDX_W];
    assign rd_pos  = rd_pc_i[OFFSET_BITS-1 -: POS_W];
    assign wr_idx  = wr_i.index[IDX_W-1:0];
    assign wr_last = &wr_i.pos;

    // line becomes valid together with its last pair
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_i.we && wr_last) begin
            valid_q[wr_i.way][wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            data_mem[wr_i.way][{wr_idx, wr_i.pos}] <= wr_i.pair;
            if (wr_last) begin
                tag_mem[wr_i.way][wr_idx] <= wr_i.tag;
            end
        end
        // both ways read in parallel
        if (rd_en_i) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                tags_o[w].valid <= valid_q[w][rd_idx];
                tags_o[w].tag   <= tag_mem[w][rd_idx];
                pairs_o[w]      <= data_mem[w][{rd_idx, rd_pos}];
            end
        end
    end

endmodule

/* common/icache_pkg.sv */
package icache_pkg;

    // line and fetch geometry
    parameter int LINE_WORDS  = 8;
    parameter int OFFSET_BITS = 5;
    parameter int FETCH_WORDS = 2;
    // victim choice is a single bit per set, so two ways only
    parameter int WAY_NUM     = 2;
    parameter int TAG_BITS    = 20;

    // request from the fetch stage
    typedef struct packed {
        logic [31:0]            pc;
        logic [FETCH_WORDS-1:0] mask;
    } fetch_pkt_t;

    // response towards decode, insts[0] is the word at pc
    typedef struct packed {
        logic [31:0]                  pc;
        logic [FETCH_WORDS-1:0]       mask;
        logic [FETCH_WORDS-1:0][31:0] insts;
    } fetch_rsp_t;

    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    // one refill write, a word pair plus the tag for the last pair
    typedef struct packed {
        logic                                      we;
        logic [$clog2(WAY_NUM)-1:0]                way;
        logic [31-OFFSET_BITS-TAG_BITS:0]          index;
        logic [$clog2(LINE_WORDS/FETCH_WORDS)-1:0] pos;
        logic [TAG_BITS-1:0]                       tag;
        logic [FETCH_WORDS-1:0][31:0]              pair;
    } line_write_t;

    // burst read on the memory port
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } mem_req_t;

endpackage
